// File: Makefile
# Verilator build for the button front end testbench
# run from the project root; override variables on the command line

VERILATOR ?= verilator
TOP       ?= button_input_tb
FILELIST  ?= button_input.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a failing check ends in $$fatal, which gives a non-zero exit status
run: compile
	$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/button_input_asserts.sv
/*
  Concurrent assertions on the button front end outputs.
  Bound into button_input; checks pulse width, press/release exclusion
  and that the clean level only moves with the delayed sample strobe.
*/

`timescale 1ns/1ns

module button_input_asserts (
  input logic                      clk,
  input logic                      nrst,
  input logic                      level_strobe,
  input db_types_pkg::btn_vec_t    level,
  input db_types_pkg::btn_events_t events
);

  import db_types_pkg::*;

  localparam int EVT_BITS = $bits(btn_events_t);

  // flat view of all pulse bits
  logic [EVT_BITS-1:0] evt_bits;
  assign evt_bits = events;

  // one button never reports press and release in the same cycle
  a_press_release_excl: assert property (@(posedge clk) disable iff (!nrst)
    (events.pressed & events.released) == '0)
    else $error("pressed and released fired together");

  // level moves only in the cycle carrying the delayed strobe
  a_level_on_strobe: assert property (@(posedge clk) disable iff (!nrst)
    !$stable(level) |-> level_strobe)
    else $error("level changed between sample strobes");

  for (genvar i = 0; i < EVT_BITS; i++) begin : g_pulse
    a_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
      evt_bits[i] |=> !evt_bits[i])
      else $error("event bit %0d stayed high for more than one cycle", i);
  end

endmodule

bind button_input button_input_asserts u_asserts (
  .clk          (clk),
  .nrst         (nrst),
  .level_strobe (level_strobe),
  .level        (level),
  .events       (events)
);

// File: bench/button_input_stim.txt
// columns (hex): ena btn_raw hold_cycles level press_cnt release_cnt long_cnt
// count columns hold one nibble per button, button 3 leftmost
// reset state
1 0 0a 0 0000 0000 0000
// single button press and release
1 1 08 1 0001 0000 0000
1 0 08 0 0001 0001 0000
// short glitches never reach level
1 2 02 0 0001 0001 0000
1 0 14 0 0001 0001 0000
1 1 01 0 0001 0001 0000
1 0 14 0 0001 0001 0000
// glitch low on a held button, long hold fires long_press once
1 4 08 4 0101 0001 0000
1 0 02 4 0101 0001 0000
1 4 1c 4 0101 0001 0100
1 0 08 0 0101 0101 0100
// short press gives no long_press, long press exactly one
1 8 08 8 1101 0101 0100
1 0 08 0 1101 1101 0100
1 8 30 8 2101 1101 1100
1 0 08 0 2101 2101 1100
// sampling disabled holds level, change follows once enabled
0 2 20 0 2101 2101 1100
1 2 08 2 2111 2101 1100
0 0 20 2 2111 2101 1100
1 0 08 0 2111 2111 1100
// independent buttons, together and separately
1 5 08 5 2212 2111 1100
1 0 08 0 2212 2212 1100
1 2 03 2 2222 2212 1100
1 a 03 a 3222 2212 1100
1 a 30 a 3222 2212 2110
1 8 08 8 3222 2222 2110
1 0 08 0 3222 3222 2110

// File: bench/button_input_tb.sv
/*
  Testbench for the push button front end.
  Replays the steps of the stim data file against button_input, counts the
  press, release and long-press pulses and checks level and counts per step.
  Run from the project root so the data file path resolves.
*/

`timescale 1ns/1ns

module button_input_tb;

  import db_cfg_pkg::*;
  import db_types_pkg::*;

  localparam int    CLK_PERIOD    = 8;
  localparam int    RESET_CYCLES  = 5;
  localparam int    STROBE_CYCLES = 1 << SAMPLE_SHIFT;
  // a clean change needs at most three strobe periods, so six is generous
  localparam int    LEVEL_TIMEOUT = 6 * STROBE_CYCLES;
  localparam string STIM_FILE     = "bench/button_input_stim.txt";

  logic        clk;
  logic        nrst;
  logic        ena;
  btn_vec_t    btn_raw;
  btn_vec_t    level;
  btn_events_t events;

  // pulses seen so far per button
  int press_cnt   [NUM_BTN];
  int release_cnt [NUM_BTN];
  int long_cnt    [NUM_BTN];

  // stim file line of the step being run
  int cur_line;

  button_input dut (
    .clk     (clk),
    .nrst    (nrst),
    .ena     (ena),
    .btn_raw (btn_raw),
    .level   (level),
    .events  (events)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------------------
  // event monitor
  // ------------------------------------------------------------------------

  // outputs are registered, so the posedge sees last cycle's pulses
  always @(posedge clk) begin
    for (int i = 0; i < NUM_BTN; i++) begin
      if (!nrst) begin
        press_cnt[i]   <= 0;
        release_cnt[i] <= 0;
        long_cnt[i]    <= 0;
      end else begin
        if (events.pressed[i])    press_cnt[i]   <= press_cnt[i] + 1;
        if (events.released[i])   release_cnt[i] <= release_cnt[i] + 1;
        if (events.long_press[i]) long_cnt[i]    <= long_cnt[i] + 1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // checks and waits
  // ------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s at stim line %0d: got 0x%0h, expected 0x%0h",
               name, cur_line, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // polls level on each falling edge until it matches
  task automatic wait_level(input btn_vec_t expected);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (level !== expected) begin
      if (cycles >= LEVEL_TIMEOUT) begin
        $display("level never reached 0x%0h within %0d cycles at stim line %0d",
                 expected, LEVEL_TIMEOUT, cur_line);
        $display("TESTBENCH FAILED");
        $fatal(1, "level wait timed out");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // one stim step drives the inputs, waits for a due level change, holds and checks
  task automatic run_step(input logic ena_v, input btn_vec_t btn_v, input int hold,
                          input btn_vec_t exp_level,
                          input logic [4*NUM_BTN-1:0] exp_press,
                          input logic [4*NUM_BTN-1:0] exp_release,
                          input logic [4*NUM_BTN-1:0] exp_long);
    logic need_wait;
    need_wait = (level !== exp_level);
    @(posedge clk);
    ena     <= ena_v;
    btn_raw <= btn_v;
    if (need_wait) begin
      wait_level(exp_level);
    end
    repeat (hold) @(posedge clk);
    @(negedge clk);
    check_value("level", 32'(level), 32'(exp_level));
    for (int i = 0; i < NUM_BTN; i++) begin
      check_value($sformatf("pressed count[%0d]", i), press_cnt[i],
                  32'(exp_press[4*i +: 4]));
      check_value($sformatf("released count[%0d]", i), release_cnt[i],
                  32'(exp_release[4*i +: 4]));
      check_value($sformatf("long_press count[%0d]", i), long_cnt[i],
                  32'(exp_long[4*i +: 4]));
    end
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial begin
    int          fd;
    int          rc;
    int          steps;
    string       text;
    logic [31:0] f_ena, f_btn, f_hold, f_level, f_press, f_release, f_long;
    nrst     <= 1'b0;
    ena      <= 1'b0;
    btn_raw  <= '0;
    cur_line = 0;
    steps    = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      $display("TESTBENCH FAILED");
      $fatal(1, "no stimulus");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    nrst <= 1'b1;
    while (!$feof(fd)) begin
      rc = $fgets(text, fd);
      cur_line++;
      // comment and blank lines scan no fields
      rc = $sscanf(text, "%h %h %h %h %h %h %h",
                   f_ena, f_btn, f_hold, f_level, f_press, f_release, f_long);
      if (rc == 7) begin
        run_step(f_ena[0], btn_vec_t'(f_btn), int'(f_hold), btn_vec_t'(f_level),
                 f_press[4*NUM_BTN-1:0], f_release[4*NUM_BTN-1:0],
                 f_long[4*NUM_BTN-1:0]);
        steps++;
      end else if (rc > 0) begin
        $display("stim line %0d has %0d fields instead of 7", cur_line, rc);
        $display("TESTBENCH FAILED");
        $fatal(1, "bad stimulus line");
      end
    end
    $fclose(fd);
    if (steps == 0) begin
      $display("the stimulus file held no steps");
      $display("TESTBENCH FAILED");
      $fatal(1, "empty stimulus");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: button_input.f
verilog/db_cfg_pkg.sv
verilog/db_types_pkg.sv
verilog/button_sampler.sv
verilog/debounce_filter.sv
verilog/button_events.sv
verilog/button_input.sv
bench/button_input_asserts.sv
bench/button_input_tb.sv

// File: verilog/button_events.sv
/*
  Last stage of the button front end. Turns clean levels into one-cycle
  press and release pulses, and counts sample strobes while a button is
  held to give a single long-press pulse per hold.
*/

`timescale 1ns/1ns

module button_events (
  input  logic                      clk,
  input  logic                      nrst,
  input  db_types_pkg::btn_vec_t    level,
  input  logic                      level_strobe,
  output db_types_pkg::btn_events_t events
);

  import db_cfg_pkg::*;
  import db_types_pkg::*;

  // count at which the long press fires, counter saturates there
  localparam hold_cnt_t LONG_CNT = hold_cnt_t'(LONG_PRESS_SAMPLES);

  btn_vec_t  level_prev;
  hold_cnt_t hold_cnt [NUM_BTN];

  // --------------------------------------------------------------------------
  // press and release edges
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!nrst) begin
      level_prev      <= '0;
      events.pressed  <= '0;
      events.released <= '0;
    end else begin
      level_prev      <= level;
      events.pressed  <= level & ~level_prev;
      events.released <= ~level & level_prev;
    end
  end

  // --------------------------------------------------------------------------
  // long-press hold counters
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!nrst) begin
      events.long_press <= '0;
      for (int i = 0; i < NUM_BTN; i++) begin
        hold_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_BTN; i++) begin
        events.long_press[i] <= 1'b0;
        if (!level[i]) begin
          // released, next hold starts from zero
          hold_cnt[i] <= '0;
        end else if (level_strobe && hold_cnt[i] != LONG_CNT) begin
          hold_cnt[i] <= hold_cnt[i] + 1'b1;
          // fire exactly on reaching the limit
          if (hold_cnt[i] == LONG_CNT - 1'b1) begin
            events.long_press[i] <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: verilog/button_input.sv
/*
  Top level of the push button front end.
  Chains sampler, debounce filter and event generator; exposes the clean
  levels and the press, release and long-press pulses.
  ena low freezes sampling, so level and events stay quiet meanwhile.
*/

`timescale 1ns/1ns

module button_input (
  input  logic                      clk,
  input  logic                      nrst,
  input  logic                      ena,
  input  db_types_pkg::btn_vec_t    btn_raw,
  output db_types_pkg::btn_vec_t    level,
  output db_types_pkg::btn_events_t events
);

  import db_types_pkg::*;

  btn_samples_t samples;
  logic         level_strobe;

  // --------------------------------------------------------------------------
  // stage 1: synchronize and sample
  // --------------------------------------------------------------------------

  button_sampler u_sampler (
    .clk     (clk),
    .nrst    (nrst),
    .ena     (ena),
    .btn_raw (btn_raw),
    .samples (samples)
  );

  // stage 2: two-sample agreement filter
  debounce_filter u_filter (
    .clk          (clk),
    .nrst         (nrst),
    .samples      (samples),
    .level        (level),
    .level_strobe (level_strobe)
  );

  // stage 3: edge and long-press pulses
  button_events u_events (
    .clk          (clk),
    .nrst         (nrst),
    .level        (level),
    .level_strobe (level_strobe),
    .events       (events)
  );

endmodule

// File: verilog/button_sampler.sv
/*
  First stage of the button front end. Brings the raw button levels into
  the clock domain, makes a sampling strobe from a free-running divider
  and keeps the last two samples of every button for the filter.
*/

`timescale 1ns/1ns

module button_sampler (
  input  logic                       clk,
  input  logic                       nrst,
  input  logic                       ena,
  input  db_types_pkg::btn_vec_t     btn_raw,
  output db_types_pkg::btn_samples_t samples
);

  import db_cfg_pkg::*;
  import db_types_pkg::*;

  // --------------------------------------------------------------------------
  // two-flop synchronizer
  // --------------------------------------------------------------------------

  btn_vec_t sync_meta;
  btn_vec_t sync_out;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      sync_meta <= '0;
      sync_out  <= '0;
    end else begin
      sync_meta <= btn_raw;
      sync_out  <= sync_meta;
    end
  end

  // --------------------------------------------------------------------------
  // sampling divider
  // --------------------------------------------------------------------------

  logic [SAMPLE_SHIFT-1:0] div_cnt;
  logic                    div_wrap;

  // high in the last count before wrapping, one cycle per period
  assign div_wrap = &div_cnt;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // two-deep sample history
  // --------------------------------------------------------------------------

  // ena freezes the history, so nothing downstream moves either
  always_ff @(posedge clk) begin
    if (!nrst) begin
      samples <= '0;
    end else begin
      samples.strobe <= div_wrap & ena;
      if (div_wrap && ena) begin
        samples.older <= samples.newer;
        samples.newer <= sync_out;
      end
    end
  end

endmodule

// File: verilog/db_cfg_pkg.sv
/*
  Configuration constants for the push button front end.
  Every stage reads its sizes and policies from here, so a board build
  changes this package only (sampling shift and long-press length).
*/

package db_cfg_pkg;

  // --------------------------------------------------------------------------
  // button count and sampling rate
  // --------------------------------------------------------------------------

  // number of push buttons handled in parallel
  localparam int NUM_BTN = 4;

  // strobe period is 2**SAMPLE_SHIFT clocks
  // 2 keeps simulation short, a real board wants around 16
  localparam int SAMPLE_SHIFT = 2;

  // --------------------------------------------------------------------------
  // filter and event behaviour
  // --------------------------------------------------------------------------

  // encoding of db_types_pkg::unstable_policy_t
  // 0 = hold old level, 1 = treat as high, 2 = treat as low
  localparam logic [1:0] UNSTABLE_POLICY = 2'd0;

  // strobes a clean high level must last before long_press fires
  localparam int LONG_PRESS_SAMPLES = 8;

  // hold counter width, must be able to hold LONG_PRESS_SAMPLES
  localparam int HOLD_CNT_W = 4;

endpackage

// File: verilog/db_types_pkg.sv
/*
  Types shared by the button front end stages.
  Stages exchange these packed structs every cycle; no handshake is
  involved, every field is either a level or a one-cycle pulse.
*/

package db_types_pkg;

  import db_cfg_pkg::*;

  // one bit per button
  typedef logic [NUM_BTN-1:0] btn_vec_t;

  // per-button count of sample strobes while held
  typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

  // what the filter does when its two samples disagree
  // values line up with db_cfg_pkg::UNSTABLE_POLICY
  typedef enum logic [1:0] {
    POLICY_HOLD = 2'd0,
    POLICY_HIGH = 2'd1,
    POLICY_LOW  = 2'd2
  } unstable_policy_t;

  // sampler -> filter, 2*NUM_BTN+1 bits
  typedef struct packed {
    btn_vec_t older;   // sample taken one strobe earlier
    btn_vec_t newer;   // most recent sample
    logic     strobe;  // pulses with every history update
  } btn_samples_t;

  // events stage output, 3*NUM_BTN bits
  typedef struct packed {
    btn_vec_t pressed;     // one cycle after a rising clean level
    btn_vec_t released;    // one cycle after a falling clean level
    btn_vec_t long_press;  // once per hold, after LONG_PRESS_SAMPLES strobes
  } btn_events_t;

endpackage

// File: verilog/debounce_filter.sv
/*
  Second stage of the button front end. A button's clean level follows
  its samples only when the older and newer sample agree; a disagreement
  is resolved by the unstable-sample policy from the config package.
*/

`timescale 1ns/1ns

module debounce_filter (
  input  logic                       clk,
  input  logic                       nrst,
  input  db_types_pkg::btn_samples_t samples,
  output db_types_pkg::btn_vec_t     level,
  output logic                       level_strobe
);

  import db_cfg_pkg::*;
  import db_types_pkg::*;

  localparam unstable_policy_t POLICY = unstable_policy_t'(UNSTABLE_POLICY);

  btn_vec_t level_next;

  // --------------------------------------------------------------------------
  // per-button agreement check
  // --------------------------------------------------------------------------

  always_comb begin
    level_next = level;
    for (int i = 0; i < NUM_BTN; i++) begin
      if (samples.older[i] == samples.newer[i]) begin
        level_next[i] = samples.newer[i];
      end else begin
        // samples disagree, input still bouncing
        case (POLICY)
          POLICY_HIGH: level_next[i] = 1'b1;
          POLICY_LOW:  level_next[i] = 1'b0;
          default:     level_next[i] = level[i];
        endcase
      end
    end
  end

  // level lands one cycle after samples, strobe delayed to stay aligned
  always_ff @(posedge clk) begin
    if (!nrst) begin
      level        <= '0;
      level_strobe <= 1'b0;
    end else begin
      level        <= level_next;
      level_strobe <= samples.strobe;
    end
  end

endmodule
